/* list.f */
hdl/axi_bus_pkg.sv
hdl/perf_pkg.sv
hdl/perf_wr_gen.sv
hdl/perf_wr_arbiter.sv
hdl/axi_perf.sv
dv/axi_perf_assert.sv
dv/axi_perf_tb.sv

/* Bender.yml */
package:
  name: axi_perf

sources:
  - files:
      - hdl/axi_bus_pkg.sv
      - hdl/perf_pkg.sv
      - hdl/perf_wr_gen.sv
      - hdl/perf_wr_arbiter.sv
      - hdl/axi_perf.sv
  - target: test
    files:
      - dv/axi_perf_assert.sv
      - dv/axi_perf_tb.sv

/* dv/axi_perf_tb.sv */
`timescale 1ns/10ps

module axi_perf_tb;

  localparam int n_rows = 5;

  // ------------------------------------------------------------------
  // test table, one row per run
  // ------------------------------------------------------------------
  localparam logic [1:0] row_mask [n_rows] = '{2'b01, 2'b10, 2'b11, 2'b11, 2'b01};
  // second start hits an idle generator that has bursts configured
  localparam bit row_restart [n_rows] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

  localparam logic [axi_bus_pkg::addr_w-1:0] row_base [n_rows][2] = '{
    '{20'h01000, 20'h00000}, '{20'h00000, 20'h20010}, '{20'h00200, 20'h80000},
    '{20'h00000, 20'h0fff0}, '{20'h00000, 20'h00000}};
  localparam logic [axi_bus_pkg::addr_w-1:0] row_stride [n_rows][2] = '{
    '{20'h00040, 20'h00000}, '{20'h00000, 20'h00100}, '{20'h00020, 20'h01000},
    '{20'h00000, 20'h00008}, '{20'h00010, 20'h00000}};
  // len codes, beats minus one
  localparam logic [perf_pkg::beats_w-1:0] row_len [n_rows][2] = '{
    '{8'd3, 8'd0}, '{8'd0, 8'd0}, '{8'd7, 8'd2}, '{8'd0, 8'd1}, '{8'd3, 8'd0}};
  localparam logic [perf_pkg::count_w-1:0] row_num [n_rows][2] = '{
    '{16'd4, 16'd2}, '{16'd0, 16'd3}, '{16'd5, 16'd6}, '{16'd0, 16'd4}, '{16'd0, 16'd0}};

  logic                                                clk;
  logic                                                rst_n;
  logic [perf_pkg::num_m-1:0]                          start;
  logic [perf_pkg::num_m-1:0][axi_bus_pkg::addr_w-1:0] base_addr;
  logic [perf_pkg::num_m-1:0][axi_bus_pkg::addr_w-1:0] stride;
  logic [perf_pkg::num_m-1:0][perf_pkg::beats_w-1:0]   burst_len;
  logic [perf_pkg::num_m-1:0][perf_pkg::count_w-1:0]   burst_num;
  logic                                                idle;

  logic                           m_axi_awvalid;
  logic [axi_bus_pkg::addr_w-1:0] m_axi_awaddr;
  logic [axi_bus_pkg::id_w-1:0]   m_axi_awid;
  logic [perf_pkg::beats_w-1:0]   m_axi_awlen;
  logic [2:0]                     m_axi_awsize;
  logic [1:0]                     m_axi_awburst;
  logic                           m_axi_awready;
  logic                           m_axi_wvalid;
  logic [axi_bus_pkg::data_w-1:0] m_axi_wdata;
  logic [axi_bus_pkg::strb_w-1:0] m_axi_wstrb;
  logic                           m_axi_wlast;
  logic                           m_axi_wready;
  logic                           m_axi_bvalid;
  logic [axi_bus_pkg::id_w-1:0]   m_axi_bid;
  logic [1:0]                     m_axi_bresp;
  logic                           m_axi_bready;

  // collected traffic of the current row
  int                             aw_mgr_q [$];
  logic [axi_bus_pkg::addr_w-1:0] aw_addr_q [$];
  logic [perf_pkg::beats_w-1:0]   aw_len_q [$];
  int                             w_mgr_q [$];
  logic [axi_bus_pkg::data_w-1:0] w_data_q [$];
  logic                           w_last_q [$];
  logic [axi_bus_pkg::id_w-1:0]   b_pending [$];
  logic [axi_bus_pkg::id_w-1:0]   cur_id;
  int                             cur_mgr;
  int                             b_count;
  int                             b_wait;
  bit                             b_taken;

  axi_perf uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic halt_failed();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic fail_with(input string why);
    $display("%s", why);
    halt_failed();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    halt_failed();
  endtask

  // ------------------------------------------------------------------
  // memory side: random ready, delayed B
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(61168));
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    m_axi_bid     = '0;
    m_axi_bresp   = axi_bus_pkg::OKAY;
    b_wait        = -1;
    forever begin
      @(negedge clk);
      m_axi_awready = (($urandom % 4) != 0);
      m_axi_wready  = (($urandom % 4) != 0);
      if (b_taken) begin
        m_axi_bvalid = 1'b0;
        b_taken      = 1'b0;
      end
      if (!m_axi_bvalid && (b_pending.size() != 0)) begin
        if (b_wait < 0) begin
          b_wait = $urandom % 4;
        end
        if (b_wait == 0) begin
          m_axi_bvalid = 1'b1;
          m_axi_bid    = b_pending.pop_front();
          b_wait       = -1;
        end else begin
          b_wait--;
        end
      end
    end
  end

  // handshake monitor
  always @(posedge clk) begin
    if (rst_n) begin
      if (m_axi_awvalid && m_axi_awready) begin
        assert (m_axi_awsize == axi_bus_pkg::size_full && m_axi_awburst == axi_bus_pkg::INCR)
          else fail_with("write burst issued with a wrong size or burst type");
        assert (m_axi_awid[axi_bus_pkg::id_w-2:0] == '0)
          else report_mismatch("m_axi_awid", m_axi_awid, {m_axi_awid[axi_bus_pkg::id_w-1], 3'b0});
        cur_id  = m_axi_awid;
        cur_mgr = m_axi_awid[axi_bus_pkg::id_w-1];
        aw_mgr_q.push_back(cur_mgr);
        aw_addr_q.push_back(m_axi_awaddr);
        aw_len_q.push_back(m_axi_awlen);
      end
      if (m_axi_wvalid && m_axi_wready) begin
        assert (m_axi_wstrb == '1) else report_mismatch("m_axi_wstrb", m_axi_wstrb, 2'b11);
        w_mgr_q.push_back(cur_mgr);
        w_data_q.push_back(m_axi_wdata);
        w_last_q.push_back(m_axi_wlast);
        if (m_axi_wlast) begin
          b_pending.push_back(cur_id);
        end
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_count++;
        b_taken = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // expected traffic from the row configuration
  // ------------------------------------------------------------------
  task automatic check_traffic(input int r, input int total);
    int                             k [2];
    int                             be [2];
    int                             m;
    logic [axi_bus_pkg::addr_w-1:0] exp_addr;
    k  = '{0, 0};
    be = '{0, 0};
    assert (aw_mgr_q.size() == total) else report_mismatch("burst count", aw_mgr_q.size(), total);
    foreach (aw_mgr_q[i]) begin
      m = aw_mgr_q[i];
      assert (row_mask[r][m] && (k[m] < row_num[r][m]))
        else fail_with("a write burst came from a generator with no bursts left");
      exp_addr = row_base[r][m] + 20'(k[m]) * row_stride[r][m];
      assert (aw_addr_q[i] == exp_addr)
        else report_mismatch("m_axi_awaddr", aw_addr_q[i], exp_addr);
      assert (aw_len_q[i] == row_len[r][m])
        else report_mismatch("m_axi_awlen", aw_len_q[i], row_len[r][m]);
      k[m]++;
    end
    k = '{0, 0};
    foreach (w_mgr_q[i]) begin
      m = w_mgr_q[i];
      exp_addr = row_base[r][m] + 20'(k[m]) * row_stride[r][m]
                 + 20'(be[m] * perf_pkg::beat_bytes);
      assert (w_data_q[i] == exp_addr[axi_bus_pkg::data_w-1:0])
        else report_mismatch("m_axi_wdata", w_data_q[i], exp_addr[axi_bus_pkg::data_w-1:0]);
      assert (w_last_q[i] == (be[m] == row_len[r][m]))
        else report_mismatch("m_axi_wlast", w_last_q[i], (be[m] == row_len[r][m]));
      if (be[m] == row_len[r][m]) begin
        be[m] = 0;
        k[m]++;
      end else begin
        be[m]++;
      end
    end
    for (int g = 0; g < 2; g++) begin
      assert ((be[g] == 0) && (k[g] == (row_mask[r][g] ? int'(row_num[r][g]) : 0)))
        else fail_with("write beats are missing for a generator");
    end
  endtask

  task automatic apply_row(input int r);
    int total;
    total = 0;
    for (int g = 0; g < 2; g++) begin
      if (row_mask[r][g]) total += row_num[r][g];
      base_addr[g] = row_base[r][g];
      stride[g]    = row_stride[r][g];
      burst_len[g] = row_len[r][g];
      burst_num[g] = row_num[r][g];
    end
    aw_mgr_q.delete();
    aw_addr_q.delete();
    aw_len_q.delete();
    w_mgr_q.delete();
    w_data_q.delete();
    w_last_q.delete();
    b_count = 0;
    start = row_mask[r];
    @(negedge clk);
    start = '0;
    assert (!idle) else fail_with("idle stayed high after a start");
    if (row_restart[r]) begin
      repeat (3) @(negedge clk);
      assert (!idle) else fail_with("run ended before the second start was applied");
      start = '1;
      @(negedge clk);
      start = '0;
    end
    while (!idle) @(negedge clk);
    assert (b_count == total) else report_mismatch("b response count", b_count, total);
    repeat (4) @(negedge clk);
    check_traffic(r, total);
  endtask

  // ------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------
  initial begin
    rst_n     = 1'b0;
    start     = '0;
    base_addr = '0;
    stride    = '0;
    burst_len = '0;
    burst_num = '0;
    b_count   = 0;
    b_taken   = 1'b0;
    cur_mgr   = 0;
    cur_id    = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (idle) else fail_with("idle is low after reset");
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    if (uut.chk.fail_cnt != 0) begin
      fail_with("bound protocol assertions failed during the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  initial begin
    int limit;
    limit = 200 + n_rows * 20;
    for (int r = 0; r < n_rows; r++) begin
      for (int g = 0; g < 2; g++) begin
        if (row_mask[r][g]) limit += row_num[r][g] * (row_len[r][g] + 1 + 8) * 4;
      end
    end
    repeat (limit) @(posedge clk);
    fail_with("watchdog expired before all rows finished");
  end

endmodule

/* dv/axi_perf_assert.sv */
`timescale 1ns/10ps

module axi_perf_assert (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           awvalid,
  input logic                           awready,
  input logic [axi_bus_pkg::addr_w-1:0] awaddr,
  input logic [axi_bus_pkg::id_w-1:0]   awid,
  input logic [perf_pkg::beats_w-1:0]   awlen,
  input logic                           wvalid,
  input logic                           wready,
  input logic [axi_bus_pkg::data_w-1:0] wdata,
  input logic                           wlast
);

  int fail_cnt = 0;

  // beat position inside the current burst
  logic [perf_pkg::beats_w-1:0] cur_len;
  logic [perf_pkg::beats_w-1:0] beat_idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cur_len  <= '0;
      beat_idx <= '0;
    end else if (awvalid && awready) begin
      cur_len  <= awlen;
      beat_idx <= '0;
    end else if (wvalid && wready) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen) && $stable(awid))
    else begin
      $error("aw valid or payload changed while stalled");
      fail_cnt++;
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else begin
      $error("w valid or payload changed while stalled");
      fail_cnt++;
    end

  w_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && wready |-> (wlast == (beat_idx == cur_len)))
    else begin
      $error("wlast not on beat awlen+1");
      fail_cnt++;
    end

endmodule

bind axi_perf axi_perf_assert chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .awvalid (m_axi_awvalid),
  .awready (m_axi_awready),
  .awaddr  (m_axi_awaddr),
  .awid    (m_axi_awid),
  .awlen   (m_axi_awlen),
  .wvalid  (m_axi_wvalid),
  .wready  (m_axi_wready),
  .wdata   (m_axi_wdata),
  .wlast   (m_axi_wlast)
);

/* hdl/axi_perf.sv */
`timescale 1ns/10ps

module axi_perf (
  input  logic                                                clk,
  input  logic                                                rst_n,

  input  logic [perf_pkg::num_m-1:0]                          start,
  input  logic [perf_pkg::num_m-1:0][axi_bus_pkg::addr_w-1:0] base_addr,
  input  logic [perf_pkg::num_m-1:0][axi_bus_pkg::addr_w-1:0] stride,
  input  logic [perf_pkg::num_m-1:0][perf_pkg::beats_w-1:0]   burst_len,
  input  logic [perf_pkg::num_m-1:0][perf_pkg::count_w-1:0]   burst_num,
  output logic                                                idle,

  output logic                                                m_axi_awvalid,
  output logic [axi_bus_pkg::addr_w-1:0]                      m_axi_awaddr,
  output logic [axi_bus_pkg::id_w-1:0]                        m_axi_awid,
  output logic [perf_pkg::beats_w-1:0]                        m_axi_awlen,
  output logic [2:0]                                          m_axi_awsize,
  output logic [1:0]                                          m_axi_awburst,
  input  logic                                                m_axi_awready,

  output logic                                                m_axi_wvalid,
  output logic [axi_bus_pkg::data_w-1:0]                      m_axi_wdata,
  output logic [axi_bus_pkg::strb_w-1:0]                      m_axi_wstrb,
  output logic                                                m_axi_wlast,
  input  logic                                                m_axi_wready,

  input  logic                                                m_axi_bvalid,
  input  logic [axi_bus_pkg::id_w-1:0]                        m_axi_bid,
  input  logic [1:0]                                          m_axi_bresp,
  output logic                                                m_axi_bready
);

  perf_pkg::run_state_t state;

  logic [perf_pkg::num_m-1:0]                          gen_start;
  logic [perf_pkg::num_m-1:0]                          gen_busy;

  logic [perf_pkg::num_m-1:0]                          gen_aw_valid;
  logic [perf_pkg::num_m-1:0][axi_bus_pkg::addr_w-1:0] gen_aw_addr;
  logic [perf_pkg::num_m-1:0][perf_pkg::beats_w-1:0]   gen_aw_len;
  logic [perf_pkg::num_m-1:0]                          gen_aw_ready;
  logic [perf_pkg::num_m-1:0]                          gen_w_valid;
  logic [perf_pkg::num_m-1:0][axi_bus_pkg::data_w-1:0] gen_w_data;
  logic [perf_pkg::num_m-1:0]                          gen_w_last;
  logic [perf_pkg::num_m-1:0]                          gen_w_ready;
  logic [perf_pkg::num_m-1:0]                          gen_b_valid;
  logic [perf_pkg::num_m-1:0]                          gen_b_ready;

  // ------------------------------------------------------------------
  // run controller
  // ------------------------------------------------------------------
  // start mask only counts while idle
  assign gen_start = (state == perf_pkg::RUN_IDLE) ? start : '0;
  assign idle      = (state == perf_pkg::RUN_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= perf_pkg::RUN_IDLE;
    end else begin
      case (state)
        perf_pkg::RUN_IDLE: if (|start) state <= perf_pkg::RUN_BUSY;
        perf_pkg::RUN_BUSY: if (!(|gen_busy)) state <= perf_pkg::RUN_IDLE;
        default:            state <= perf_pkg::RUN_IDLE;
      endcase
    end
  end

  // fixed write attributes
  assign m_axi_awsize  = axi_bus_pkg::size_full;
  assign m_axi_awburst = axi_bus_pkg::INCR;
  assign m_axi_wstrb   = '1;

  // ------------------------------------------------------------------
  // generators and merge
  // ------------------------------------------------------------------
  perf_wr_gen gen_0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (gen_start[0]),
    .base_addr (base_addr[0]),
    .stride    (stride[0]),
    .burst_len (burst_len[0]),
    .burst_num (burst_num[0]),
    .busy      (gen_busy[0]),
    .aw_valid  (gen_aw_valid[0]),
    .aw_addr   (gen_aw_addr[0]),
    .aw_len    (gen_aw_len[0]),
    .aw_ready  (gen_aw_ready[0]),
    .w_valid   (gen_w_valid[0]),
    .w_data    (gen_w_data[0]),
    .w_last    (gen_w_last[0]),
    .w_ready   (gen_w_ready[0]),
    .b_valid   (gen_b_valid[0]),
    .b_ready   (gen_b_ready[0])
  );

  perf_wr_gen gen_1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (gen_start[1]),
    .base_addr (base_addr[1]),
    .stride    (stride[1]),
    .burst_len (burst_len[1]),
    .burst_num (burst_num[1]),
    .busy      (gen_busy[1]),
    .aw_valid  (gen_aw_valid[1]),
    .aw_addr   (gen_aw_addr[1]),
    .aw_len    (gen_aw_len[1]),
    .aw_ready  (gen_aw_ready[1]),
    .w_valid   (gen_w_valid[1]),
    .w_data    (gen_w_data[1]),
    .w_last    (gen_w_last[1]),
    .w_ready   (gen_w_ready[1]),
    .b_valid   (gen_b_valid[1]),
    .b_ready   (gen_b_ready[1])
  );

  perf_wr_arbiter arb (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw_valid      (gen_aw_valid),
    .aw_addr       (gen_aw_addr),
    .aw_len        (gen_aw_len),
    .aw_ready      (gen_aw_ready),
    .w_valid       (gen_w_valid),
    .w_data        (gen_w_data),
    .w_last        (gen_w_last),
    .w_ready       (gen_w_ready),
    .b_valid       (gen_b_valid),
    .b_ready       (gen_b_ready),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awid    (m_axi_awid),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awready (m_axi_awready),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bid     (m_axi_bid),
    .m_axi_bready  (m_axi_bready)
  );

endmodule

/* hdl/perf_wr_arbiter.sv */
`timescale 1ns/10ps

module perf_wr_arbiter (
  input  logic                                                clk,
  input  logic                                                rst_n,

  // generator side
  input  logic [perf_pkg::num_m-1:0]                          aw_valid,
  input  logic [perf_pkg::num_m-1:0][axi_bus_pkg::addr_w-1:0] aw_addr,
  input  logic [perf_pkg::num_m-1:0][perf_pkg::beats_w-1:0]   aw_len,
  output logic [perf_pkg::num_m-1:0]                          aw_ready,

  input  logic [perf_pkg::num_m-1:0]                          w_valid,
  input  logic [perf_pkg::num_m-1:0][axi_bus_pkg::data_w-1:0] w_data,
  input  logic [perf_pkg::num_m-1:0]                          w_last,
  output logic [perf_pkg::num_m-1:0]                          w_ready,

  output logic [perf_pkg::num_m-1:0]                          b_valid,
  input  logic [perf_pkg::num_m-1:0]                          b_ready,

  // memory side
  output logic                                                m_axi_awvalid,
  output logic [axi_bus_pkg::addr_w-1:0]                      m_axi_awaddr,
  output logic [axi_bus_pkg::id_w-1:0]                        m_axi_awid,
  output logic [perf_pkg::beats_w-1:0]                        m_axi_awlen,
  input  logic                                                m_axi_awready,

  output logic                                                m_axi_wvalid,
  output logic [axi_bus_pkg::data_w-1:0]                      m_axi_wdata,
  output logic                                                m_axi_wlast,
  input  logic                                                m_axi_wready,

  input  logic                                                m_axi_bvalid,
  input  logic [axi_bus_pkg::id_w-1:0]                        m_axi_bid,
  output logic                                                m_axi_bready
);

  logic                         owned;
  logic [perf_pkg::mgr_w-1:0]   owner;
  logic [perf_pkg::mgr_w-1:0]   last_win;
  logic                         aw_done;
  logic                         w_done;

  logic [perf_pkg::mgr_w-1:0]   pick;
  logic [perf_pkg::mgr_w-1:0]   sel;
  logic [perf_pkg::mgr_w-1:0]   bsel;
  logic                         aw_phase;
  logic                         w_phase;

  // ------------------------------------------------------------------
  // round robin, nearest requester past the last winner
  // ------------------------------------------------------------------
  always_comb begin
    int idx;
    pick = last_win;
    for (int i = perf_pkg::num_m; i >= 1; i--) begin
      idx = (int'(last_win) + i) % perf_pkg::num_m;
      if (aw_valid[idx]) begin
        pick = perf_pkg::mgr_w'(idx);
      end
    end
  end

  // grant holds once taken
  assign sel      = owned ? owner : pick;
  assign aw_phase = !owned || !aw_done;
  assign w_phase  = owned && aw_done && !w_done;

  // ------------------------------------------------------------------
  // channel muxes
  // ------------------------------------------------------------------
  assign m_axi_awvalid = aw_phase && aw_valid[sel];
  assign m_axi_awaddr  = aw_addr[sel];
  assign m_axi_awlen   = aw_len[sel];
  assign m_axi_awid    = {sel, {(axi_bus_pkg::id_w - perf_pkg::mgr_w){1'b0}}};

  assign m_axi_wvalid  = w_phase && w_valid[owner];
  assign m_axi_wdata   = w_data[owner];
  assign m_axi_wlast   = w_last[owner];

  // response goes back by the manager bits of the id
  assign bsel         = m_axi_bid[axi_bus_pkg::id_w-1 -: perf_pkg::mgr_w];
  assign m_axi_bready = b_ready[bsel];

  always_comb begin
    aw_ready       = '0;
    w_ready        = '0;
    b_valid        = '0;
    aw_ready[sel]  = aw_phase && m_axi_awready;
    w_ready[owner] = w_phase && m_axi_wready;
    b_valid[bsel]  = m_axi_bvalid;
  end

  // ------------------------------------------------------------------
  // ownership of the write port
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owned    <= 1'b0;
      owner    <= '0;
      last_win <= perf_pkg::mgr_w'(perf_pkg::num_m - 1);
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
    end else if (!owned) begin
      if (|aw_valid) begin
        owned    <= 1'b1;
        owner    <= pick;
        last_win <= pick;
        aw_done  <= m_axi_awready;
        w_done   <= 1'b0;
      end
    end else begin
      if (m_axi_awvalid && m_axi_awready) begin
        aw_done <= 1'b1;
      end
      if (m_axi_wvalid && m_axi_wready && m_axi_wlast) begin
        w_done <= 1'b1;
      end
      // released after the write response
      if (w_done && m_axi_bvalid && m_axi_bready) begin
        owned   <= 1'b0;
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    end
  end

endmodule

/* hdl/perf_wr_gen.sv */
`timescale 1ns/10ps

module perf_wr_gen (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             start,
  input  logic [axi_bus_pkg::addr_w-1:0]   base_addr,
  input  logic [axi_bus_pkg::addr_w-1:0]   stride,
  input  logic [perf_pkg::beats_w-1:0]     burst_len,
  input  logic [perf_pkg::count_w-1:0]     burst_num,
  output logic                             busy,

  output logic                             aw_valid,
  output logic [axi_bus_pkg::addr_w-1:0]   aw_addr,
  output logic [perf_pkg::beats_w-1:0]     aw_len,
  input  logic                             aw_ready,

  output logic                             w_valid,
  output logic [axi_bus_pkg::data_w-1:0]   w_data,
  output logic                             w_last,
  input  logic                             w_ready,

  input  logic                             b_valid,
  output logic                             b_ready
);

  perf_pkg::gen_state_t state;

  // captured on start
  logic [axi_bus_pkg::addr_w-1:0] cfg_stride;
  logic [perf_pkg::beats_w-1:0]   cfg_len;

  // position in the run
  logic [perf_pkg::count_w-1:0]   burst_left;
  logic [perf_pkg::beats_w-1:0]   beat_cnt;
  logic [axi_bus_pkg::addr_w-1:0] burst_addr;
  logic [axi_bus_pkg::addr_w-1:0] beat_addr;

  logic aw_hs;
  logic w_hs;
  logic b_hs;

  // ------------------------------------------------------------------
  // outputs straight from state
  // ------------------------------------------------------------------
  assign busy     = (state != perf_pkg::GEN_IDLE);
  assign aw_valid = (state == perf_pkg::GEN_ADDR);
  assign aw_addr  = burst_addr;
  assign aw_len   = cfg_len;

  assign w_valid  = (state == perf_pkg::GEN_DATA);
  assign w_data   = beat_addr[axi_bus_pkg::data_w-1:0];
  assign w_last   = (beat_cnt == cfg_len);

  assign b_ready  = (state == perf_pkg::GEN_RESP);

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign b_hs  = b_valid && b_ready;

  // ------------------------------------------------------------------
  // burst walker
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= perf_pkg::GEN_IDLE;
      burst_left <= '0;
      beat_cnt   <= '0;
    end else begin
      case (state)
        perf_pkg::GEN_IDLE: begin
          // zero bursts means nothing to do
          if (start && (burst_num != '0)) begin
            state      <= perf_pkg::GEN_ADDR;
            burst_left <= burst_num;
          end
        end

        perf_pkg::GEN_ADDR: begin
          if (aw_hs) begin
            state    <= perf_pkg::GEN_DATA;
            beat_cnt <= '0;
          end
        end

        perf_pkg::GEN_DATA: begin
          if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (w_last) begin
              state <= perf_pkg::GEN_RESP;
            end
          end
        end

        perf_pkg::GEN_RESP: begin
          if (b_hs) begin
            burst_left <= burst_left - 1'b1;
            if (burst_left == perf_pkg::count_w'(1)) begin
              state <= perf_pkg::GEN_IDLE;
            end else begin
              state <= perf_pkg::GEN_ADDR;
            end
          end
        end

        default: begin
          state <= perf_pkg::GEN_IDLE;
        end
      endcase
    end
  end

  // addresses and captured config
  always_ff @(posedge clk) begin
    if ((state == perf_pkg::GEN_IDLE) && start) begin
      burst_addr <= base_addr;
      cfg_stride <= stride;
      cfg_len    <= burst_len;
    end else if (b_hs) begin
      burst_addr <= burst_addr + cfg_stride;
    end

    if (aw_hs) begin
      beat_addr <= burst_addr;
    end else if (w_hs) begin
      beat_addr <= beat_addr + axi_bus_pkg::addr_w'(perf_pkg::beat_bytes);
    end
  end

endmodule

/* hdl/perf_pkg.sv */
package perf_pkg;

  // ------------------------------------------------------------------
  // generator configuration
  // ------------------------------------------------------------------
  localparam int num_m = 2;
  localparam int mgr_w = 1;

  // burst length held as the AXI len code, beats minus one
  localparam int beats_w = 8;
  localparam int count_w = 16;

  localparam int beat_bytes = axi_bus_pkg::data_w / 8;

  // ------------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------------
  typedef enum logic {
    RUN_IDLE,
    RUN_BUSY
  } run_state_t;

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_ADDR,
    GEN_DATA,
    GEN_RESP
  } gen_state_t;

endpackage

/* hdl/axi_bus_pkg.sv */
package axi_bus_pkg;

  // ------------------------------------------------------------------
  // write bus widths
  // ------------------------------------------------------------------
  localparam int addr_w = 20;
  localparam int data_w = 16;
  localparam int strb_w = data_w / 8;
  localparam int id_w = 4;

  // every beat uses the full data width, 2 bytes
  localparam logic [2:0] size_full = 3'd1;

  // ------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

endpackage
